// ==== common/rvc_pkg.sv ====
// shared definitions for the rv32c fetch front end
// instruction widths, boot address, major opcodes and aligner states

package rvc_pkg;

  ////////////////////////////////////////
  // widths and addresses
  ////////////////////////////////////////

  // full instruction and halfword widths in bits
  localparam int unsigned ILEN = 32;
  localparam int unsigned HLEN = 16;

  // first fetch goes here, word aligned
  localparam logic [31:0] BOOT_ADDR = 32'h0000_0080;

  ////////////////////////////////////////
  // rv32 major opcodes
  ////////////////////////////////////////

  // only the opcodes that compressed forms expand into
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  ////////////////////////////////////////
  // aligner states
  ////////////////////////////////////////

  // where the next instruction starts inside the front buffer word
  typedef enum logic {
    // low halfword of slot 0
    ALIGN_WORD = 1'b0,
    // high halfword of slot 0
    ALIGN_HALF = 1'b1
  } align_state_e;

endpackage

// ==== hw/fetch/fetch_prefetch.sv ====
// sequential fetch address generator and request strobe
// two-entry response buffer feeding the aligner

module fetch_prefetch (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     fetch_valid_i,
  input  logic [rvc_pkg::ILEN-1:0] fetch_rdata_i,
  input  logic                     pop_i,
  output logic                     fetch_req_o,
  output logic [31:0]              fetch_addr_o,
  output logic                     buf_valid0_o,
  output logic [rvc_pkg::ILEN-1:0] buf_rdata0_o,
  output logic                     buf_valid1_o,
  output logic [rvc_pkg::ILEN-1:0] buf_rdata1_o
);

  // address and strobe of the request issued this cycle
  logic [31:0] addr_q;
  logic        req_q;
  // requests sent before this cycle and not yet answered
  logic [1:0]  outst_q;
  logic [1:0]  outst_d;

  // buffer slots, slot 0 is the oldest word
  logic                     v0_q;
  logic                     v1_q;
  logic [rvc_pkg::ILEN-1:0] d0_q;
  logic [rvc_pkg::ILEN-1:0] d1_q;
  logic                     v0_d;
  logic                     v1_d;
  logic [rvc_pkg::ILEN-1:0] d0_d;
  logic [rvc_pkg::ILEN-1:0] d1_d;

  // words held next cycle plus requests still in flight
  logic [2:0] fill_d;
  logic       req_d;

  ////////////////////////////////////////
  // buffer next state
  ////////////////////////////////////////

  always_comb begin
    // retire the front word first
    v0_d = pop_i ? v1_q : v0_q;
    d0_d = pop_i ? d1_q : d0_q;
    v1_d = pop_i ? 1'b0 : v1_q;
    d1_d = d1_q;
    // a response lands behind whatever survives the pop
    if (fetch_valid_i) begin
      if (!v0_d) begin
        v0_d = 1'b1;
        d0_d = fetch_rdata_i;
      end else begin
        v1_d = 1'b1;
        d1_d = fetch_rdata_i;
      end
    end
    outst_d = outst_q + {1'b0, req_q} - {1'b0, fetch_valid_i};
    fill_d  = {2'b00, v0_d} + {2'b00, v1_d} + {1'b0, outst_d};
    // only ask when the answer is sure to find a free slot
    req_d   = (fill_d < 3'd2);
  end

  ////////////////////////////////////////
  // control registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      addr_q  <= rvc_pkg::BOOT_ADDR;
      req_q   <= 1'b0;
      outst_q <= 2'd0;
      v0_q    <= 1'b0;
      v1_q    <= 1'b0;
    end else begin
      // step to the next word once the current address went out
      if (req_q) begin
        addr_q <= addr_q + 32'(rvc_pkg::ILEN / 8);
      end
      req_q   <= req_d;
      outst_q <= outst_d;
      v0_q    <= v0_d;
      v1_q    <= v1_d;
    end
  end

  // word storage
  always_ff @(posedge clk_i) begin
    d0_q <= d0_d;
    d1_q <= d1_d;
  end

  assign fetch_req_o  = req_q;
  assign fetch_addr_o = addr_q;
  assign buf_valid0_o = v0_q;
  assign buf_rdata0_o = d0_q;
  assign buf_valid1_o = v1_q;
  assign buf_rdata1_o = d1_q;

endmodule

// ==== hw/fetch/fetch_aligner.sv ====
// halfword realignment FSM over the two buffered words
// builds the decoder candidate and retires words from the buffer

module fetch_aligner (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     buf_valid0_i,
  input  logic [rvc_pkg::ILEN-1:0] buf_rdata0_i,
  input  logic                     buf_valid1_i,
  input  logic [rvc_pkg::ILEN-1:0] buf_rdata1_i,
  input  logic                     is_compressed_i,
  input  logic                     stall_i,
  output logic [rvc_pkg::ILEN-1:0] cand_instr_o,
  output logic                     aligned_valid_o,
  output logic                     advance_o,
  output logic                     pop_o
);

  rvc_pkg::align_state_e state_q;
  rvc_pkg::align_state_e state_d;

  ////////////////////////////////////////
  // candidate selection
  ////////////////////////////////////////

  always_comb begin
    case (state_q)
      rvc_pkg::ALIGN_HALF: begin
        // upper half of slot 0 followed by lower half of slot 1
        cand_instr_o    = {buf_rdata1_i[rvc_pkg::HLEN-1:0],
                           buf_rdata0_i[rvc_pkg::ILEN-1:rvc_pkg::HLEN]};
        // a 32-bit instruction here straddles both slots
        aligned_valid_o = buf_valid0_i && (is_compressed_i || buf_valid1_i);
      end
      default: begin
        // instruction starts on the word boundary
        cand_instr_o    = buf_rdata0_i;
        aligned_valid_o = buf_valid0_i;
      end
    endcase
  end

  // hand over one instruction unless the consumer holds us
  assign advance_o = aligned_valid_o && !stall_i;

  ////////////////////////////////////////
  // state update and word retirement
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    pop_o   = 1'b0;
    if (advance_o) begin
      if (is_compressed_i) begin
        // a halfword consumed flips the alignment
        if (state_q == rvc_pkg::ALIGN_HALF) begin
          state_d = rvc_pkg::ALIGN_WORD;
          // front word is now fully used
          pop_o   = 1'b1;
        end else begin
          state_d = rvc_pkg::ALIGN_HALF;
        end
      end else begin
        // full word consumed, alignment unchanged
        pop_o = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= rvc_pkg::ALIGN_WORD;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== hw/decode/compressed_decoder.sv ====
// rv32c to rv32 expansion, purely combinational
// flags reserved and non-rv32 compressed encodings as illegal

module compressed_decoder (
  input  logic [rvc_pkg::ILEN-1:0] instr_i,
  output logic [rvc_pkg::ILEN-1:0] instr_o,
  output logic                     is_compressed_o,
  output logic                     illegal_instr_o
);

  // the compressed halfword and its common register fields
  logic [rvc_pkg::HLEN-1:0] c;
  logic [4:0]               rd;
  logic [4:0]               rs2;
  logic [4:0]               rdp;
  logic [4:0]               rs1p;
  logic [2:0]               alu_f3;

  localparam logic [4:0] REG_SP = 5'd2;
  localparam logic [4:0] REG_RA = 5'd1;

  assign c    = instr_i[rvc_pkg::HLEN-1:0];
  assign rd   = c[11:7];
  assign rs2  = c[6:2];
  // primed registers map onto x8 to x15
  assign rdp  = {2'b01, c[4:2]};
  assign rs1p = {2'b01, c[9:7]};

  // funct3 of the c.sub group, sub shares 000 with add
  always_comb begin
    case (c[6:5])
      2'b00:   alu_f3 = 3'b000;
      2'b01:   alu_f3 = 3'b100;
      2'b10:   alu_f3 = 3'b110;
      default: alu_f3 = 3'b111;
    endcase
  end

  ////////////////////////////////////////
  // expansion
  ////////////////////////////////////////

  always_comb begin
    // 32-bit instructions pass untouched
    instr_o         = instr_i;
    illegal_instr_o = 1'b0;

    case (c[1:0])
      // quadrant 0, stack and register-based memory access
      2'b00: begin
        case (c[15:13])
          3'b000: begin
            // c.addi4spn, zero immediate is reserved
            instr_o = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, REG_SP, 3'b000, rdp,
                       rvc_pkg::OPCODE_OP_IMM};
            illegal_instr_o = (c[12:5] == 8'd0);
          end
          3'b010: begin
            // c.lw, word offset scaled by 4
            instr_o = {5'd0, c[5], c[12:10], c[6], 2'b00, rs1p, 3'b010, rdp,
                       rvc_pkg::OPCODE_LOAD};
          end
          3'b110: begin
            // c.sw, offset split across the store immediate
            instr_o = {5'd0, c[5], c[12], rdp, rs1p, 3'b010, c[11:10], c[6], 2'b00,
                       rvc_pkg::OPCODE_STORE};
          end
          // fld, flw, fsd, fsw and reserved slots
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // quadrant 1, immediates, jumps and branches
      2'b01: begin
        case (c[15:13])
          3'b000: begin
            // c.addi and c.nop
            instr_o = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, rvc_pkg::OPCODE_OP_IMM};
          end
          3'b001, 3'b101: begin
            // c.jal links to ra, c.j links to x0
            instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}},
                       4'b0000, ~c[15], rvc_pkg::OPCODE_JAL};
          end
          3'b010: begin
            // c.li adds to x0
            instr_o = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, rvc_pkg::OPCODE_OP_IMM};
          end
          3'b011: begin
            if (rd == REG_SP) begin
              // c.addi16sp, immediate in units of 16
              instr_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, REG_SP, 3'b000,
                         REG_SP, rvc_pkg::OPCODE_OP_IMM};
            end else begin
              // c.lui
              instr_o = {{15{c[12]}}, c[6:2], rd, rvc_pkg::OPCODE_LUI};
            end
            // zero immediate is reserved for both
            illegal_instr_o = ({c[12], c[6:2]} == 6'd0);
          end
          3'b100: begin
            case (c[11:10])
              2'b00, 2'b01: begin
                // c.srli and c.srai, shamt bit 5 does not exist on rv32
                instr_o = {1'b0, c[10], 5'd0, c[6:2], rs1p, 3'b101, rs1p,
                           rvc_pkg::OPCODE_OP_IMM};
                illegal_instr_o = c[12];
              end
              2'b10: begin
                // c.andi
                instr_o = {{7{c[12]}}, c[6:2], rs1p, 3'b111, rs1p, rvc_pkg::OPCODE_OP_IMM};
              end
              default: begin
                // c.sub, c.xor, c.or, c.and
                instr_o = {1'b0, (c[6:5] == 2'b00), 5'd0, rdp, rs1p, alu_f3, rs1p,
                           rvc_pkg::OPCODE_OP};
                // subw and addw belong to rv64
                illegal_instr_o = c[12];
              end
            endcase
          end
          default: begin
            // c.beqz and c.bnez, funct3 bit 0 comes from bit 13
            instr_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 2'b00, c[13], c[11:10], c[4:3],
                       c[12], rvc_pkg::OPCODE_BRANCH};
          end
        endcase
      end

      // quadrant 2, full register forms and sp-relative access
      2'b10: begin
        case (c[15:13])
          3'b000: begin
            // c.slli
            instr_o = {7'd0, c[6:2], rd, 3'b001, rd, rvc_pkg::OPCODE_OP_IMM};
            illegal_instr_o = c[12];
          end
          3'b010: begin
            // c.lwsp needs a real destination
            instr_o = {4'd0, c[3:2], c[12], c[6:4], 2'b00, REG_SP, 3'b010, rd,
                       rvc_pkg::OPCODE_LOAD};
            illegal_instr_o = (rd == 5'd0);
          end
          3'b100: begin
            if (rs2 != 5'd0) begin
              // c.mv reads x0, c.add reads rd
              instr_o = {7'd0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, rvc_pkg::OPCODE_OP};
            end else if (!c[12]) begin
              // c.jr, x0 base is reserved
              instr_o = {12'd0, rd, 3'b000, 5'd0, rvc_pkg::OPCODE_JALR};
              illegal_instr_o = (rd == 5'd0);
            end else if (rd == 5'd0) begin
              // c.ebreak
              instr_o = {12'd1, 5'd0, 3'b000, 5'd0, rvc_pkg::OPCODE_SYSTEM};
            end else begin
              // c.jalr links to ra
              instr_o = {12'd0, rd, 3'b000, REG_RA, rvc_pkg::OPCODE_JALR};
            end
          end
          3'b110: begin
            // c.swsp
            instr_o = {4'd0, c[8:7], c[12], rs2, REG_SP, 3'b010, c[11:9], 2'b00,
                       rvc_pkg::OPCODE_STORE};
          end
          // floating point and reserved slots
          default: illegal_instr_o = 1'b1;
        endcase
      end

      default: ;
    endcase
  end

  // low bits 11 mark a full-length instruction
  assign is_compressed_o = (c[1:0] != 2'b11);

endmodule

// ==== hw/decode/if_output_reg.sv ====
// output register of the fetch front end
// tracks the pc and holds its data while stalled

module if_output_reg (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     advance_i,
  input  logic [rvc_pkg::ILEN-1:0] instr_i,
  input  logic [rvc_pkg::ILEN-1:0] instr_c_i,
  input  logic                     is_compressed_i,
  input  logic                     illegal_i,
  output logic                     valid_o,
  output logic [rvc_pkg::ILEN-1:0] instr_o,
  output logic [rvc_pkg::ILEN-1:0] instr_c_o,
  output logic                     is_compressed_o,
  output logic                     illegal_o,
  output logic [31:0]              pc_o
);

  // pc of the instruction the aligner currently offers
  logic [31:0] pc_q;
  logic [31:0] pc_step;

  // halfword or word step
  assign pc_step = is_compressed_i ? 32'(rvc_pkg::HLEN / 8) : 32'(rvc_pkg::ILEN / 8);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q    <= rvc_pkg::BOOT_ADDR;
      valid_o <= 1'b0;
    end else begin
      // single-cycle strobe per captured instruction
      valid_o <= advance_i;
      if (advance_i) begin
        pc_q <= pc_q + pc_step;
      end
    end
  end

  // payload only changes on a handover
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      instr_o         <= instr_i;
      instr_c_o       <= instr_c_i;
      is_compressed_o <= is_compressed_i;
      illegal_o       <= illegal_i;
      pc_o            <= pc_q;
    end
  end

endmodule

// ==== hw/rvc_fetch_top.sv ====
// rv32c instruction front end top level
// prefetch buffer, aligner, compressed decoder and output register

module rvc_fetch_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     fetch_valid_i,
  input  logic [rvc_pkg::ILEN-1:0] fetch_rdata_i,
  input  logic                     stall_i,
  output logic                     fetch_req_o,
  output logic [31:0]              fetch_addr_o,
  output logic                     valid_o,
  output logic [rvc_pkg::ILEN-1:0] instr_o,
  output logic [rvc_pkg::ILEN-1:0] instr_c_o,
  output logic                     is_compressed_o,
  output logic                     illegal_o,
  output logic [31:0]              pc_o
);

  // buffer slots toward the aligner
  logic                     buf_valid0;
  logic [rvc_pkg::ILEN-1:0] buf_rdata0;
  logic                     buf_valid1;
  logic [rvc_pkg::ILEN-1:0] buf_rdata1;
  logic                     pop;

  // aligned candidate and its decode
  logic [rvc_pkg::ILEN-1:0] cand_instr;
  logic                     aligned_valid;
  logic                     advance;
  logic                     is_compressed;
  logic [rvc_pkg::ILEN-1:0] expanded_instr;
  logic                     illegal;
  logic [rvc_pkg::ILEN-1:0] instr_c;

  ////////////////////////////////////////
  // fetch side
  ////////////////////////////////////////

  fetch_prefetch u_prefetch (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_rdata_i (fetch_rdata_i),
    .pop_i         (pop),
    .fetch_req_o   (fetch_req_o),
    .fetch_addr_o  (fetch_addr_o),
    .buf_valid0_o  (buf_valid0),
    .buf_rdata0_o  (buf_rdata0),
    .buf_valid1_o  (buf_valid1),
    .buf_rdata1_o  (buf_rdata1)
  );

  fetch_aligner u_aligner (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .buf_valid0_i    (buf_valid0),
    .buf_rdata0_i    (buf_rdata0),
    .buf_valid1_i    (buf_valid1),
    .buf_rdata1_i    (buf_rdata1),
    .is_compressed_i (is_compressed),
    .stall_i         (stall_i),
    .cand_instr_o    (cand_instr),
    .aligned_valid_o (aligned_valid),
    .advance_o       (advance),
    .pop_o           (pop)
  );

  ////////////////////////////////////////
  // decode and output
  ////////////////////////////////////////

  compressed_decoder u_decoder (
    .instr_i         (cand_instr),
    .instr_o         (expanded_instr),
    .is_compressed_o (is_compressed),
    .illegal_instr_o (illegal)
  );

  // original bits, upper half cleared for a compressed instruction
  assign instr_c = is_compressed ?
                   {{rvc_pkg::HLEN{1'b0}}, cand_instr[rvc_pkg::HLEN-1:0]} : cand_instr;

  if_output_reg u_out_reg (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .advance_i       (advance),
    .instr_i         (expanded_instr),
    .instr_c_i       (instr_c),
    .is_compressed_i (is_compressed),
    .illegal_i       (illegal),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .instr_c_o       (instr_c_o),
    .is_compressed_o (is_compressed_o),
    .illegal_o       (illegal_o),
    .pc_o            (pc_o)
  );

endmodule

// ==== sim/rvc_fetch_chk.sv ====
// bound assertions for the fetch front end
// decoder candidate sanity, memory response timing, output hold under stall

module rvc_fetch_chk (
  input logic        clk_i,
  input logic        rst_i,
  input logic        fetch_req_i,
  input logic        fetch_valid_i,
  input logic        stall_i,
  input logic        valid_i,
  input logic        aligned_valid_i,
  input logic [31:0] cand_instr_i,
  input logic [31:0] instr_i,
  input logic [31:0] instr_c_i,
  input logic [31:0] pc_i,
  input logic        is_compressed_i,
  input logic        illegal_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // payload registers start unknown until the first handover
  logic seen_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      seen_q <= 1'b0;
    end else if (valid_i) begin
      seen_q <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // properties
  ////////////////////////////////////////

  // quadrant, funct3 and selector fields the decoder branches on
  a_cand_known: assert property (@(posedge clk_i) disable iff (rst_i)
    aligned_valid_i |-> !$isunknown({cand_instr_i[15:10], cand_instr_i[6:5],
                                     cand_instr_i[1:0]}))
    else $error("decoder candidate has unknown selector bits");

  // fixed one-cycle memory response
  a_resp_timing: assert property (@(posedge clk_i) disable iff (rst_i)
    fetch_valid_i == $past(fetch_req_i))
    else $error("memory response does not follow request by one cycle");

  // no handover while stalled, payload held
  a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (seen_q && stall_i) |=> (!valid_i && $stable({instr_i, instr_c_i, pc_i,
                                                  is_compressed_i, illegal_i})))
    else $error("outputs changed while stalled");

endmodule

bind rvc_fetch_top rvc_fetch_chk chk_i (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .fetch_req_i     (fetch_req_o),
  .fetch_valid_i   (fetch_valid_i),
  .stall_i         (stall_i),
  .valid_i         (valid_o),
  .aligned_valid_i (aligned_valid),
  .cand_instr_i    (cand_instr),
  .instr_i         (instr_o),
  .instr_c_i       (instr_c_o),
  .pc_i            (pc_o),
  .is_compressed_i (is_compressed_o),
  .illegal_i       (illegal_o)
);

// ==== sim/tb_rvc_fetch.sv ====
// testbench for the rv32c fetch front end
// memory model, stimulus file reader, compare task and random stalls

module tb_rvc_fetch;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned STIM_WORDS     = 256;
  localparam logic [31:0] SENTINEL       = 32'hdead_beef;
  localparam int unsigned TIMEOUT_CYCLES = 200;

  logic        clk_i;
  logic        rst_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_rdata_i;
  logic        stall_i;
  logic        fetch_req_o;
  logic [31:0] fetch_addr_o;
  logic        valid_o;
  logic [31:0] instr_o;
  logic [31:0] instr_c_o;
  logic        is_compressed_o;
  logic        illegal_o;
  logic [31:0] pc_o;

  // image words, sentinel, records, sentinel
  logic [31:0] stim_mem [STIM_WORDS];
  int unsigned image_len;
  int unsigned rec_base;
  int unsigned rec_count;
  int unsigned err_count;
  int unsigned check_count;
  int unsigned timeout_count;
  integer      seed;
  // request seen last cycle, answered this cycle
  logic        pend_v;
  logic [31:0] pend_addr;
  logic        req_seen;
  bit          ok;

  rvc_fetch_top dut_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_rdata_i   (fetch_rdata_i),
    .stall_i         (stall_i),
    .fetch_req_o     (fetch_req_o),
    .fetch_addr_o    (fetch_addr_o),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .instr_c_o       (instr_c_o),
    .is_compressed_o (is_compressed_o),
    .illegal_o       (illegal_o),
    .pc_o            (pc_o)
  );

  always begin
    #2;
    clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // image lookup, beyond the image a fill derived from the address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - rvc_pkg::BOOT_ADDR) >> 2;
    if (addr >= rvc_pkg::BOOT_ADDR && idx < image_len) begin
      return stim_mem[idx];
    end
    return addr ^ 32'ha5a5_0000;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic load_stim();
    int unsigned pos;
    $readmemh("sim/rvc_fetch_stim.txt", stim_mem);
    image_len = 0;
    while (image_len < STIM_WORDS && stim_mem[image_len] != SENTINEL) begin
      image_len++;
    end
    rec_base = image_len + 1;
    pos      = rec_base;
    while (pos < STIM_WORDS && stim_mem[pos] != SENTINEL) begin
      pos++;
    end
    rec_count = (pos > rec_base) ? (pos - rec_base) / 5 : 0;
    if (pos >= STIM_WORDS || rec_count == 0) begin
      err_count++;
      $display("stimulus file is missing its separator lines or its records");
    end
  endtask

  // one clock, then memory response, stall and first-request check
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
    fetch_valid_i = pend_v;
    fetch_rdata_i = pend_v ? mem_word(pend_addr) : 32'h0;
    pend_v        = fetch_req_o;
    pend_addr     = fetch_addr_o;
    // stalled about one cycle in four
    stall_i       = (($random(seed) & 32'h3) == 0);
    if (!req_seen && fetch_req_o) begin
      req_seen = 1'b1;
      check_value("fetch_addr_o", rvc_pkg::BOOT_ADDR, fetch_addr_o);
    end
  endtask

  task automatic wait_valid(output bit got);
    int unsigned n;
    got = 1'b0;
    n   = 0;
    while (!got && n < TIMEOUT_CYCLES) begin
      step_cycle();
      n++;
      got = valid_o;
    end
    if (!got) begin
      timeout_count++;
      $display("timeout, no instruction came out within %0d cycles", TIMEOUT_CYCLES);
    end
  endtask

  task automatic check_record(input int unsigned r);
    int unsigned b;
    b = rec_base + r * 5;
    check_value("pc_o", stim_mem[b], pc_o);
    // expansion of an illegal encoding is not defined
    if (stim_mem[b + 4][0] == 1'b0) begin
      check_value("instr_o", stim_mem[b + 1], instr_o);
    end
    check_value("instr_c_o", stim_mem[b + 2], instr_c_o);
    check_value("is_compressed_o", stim_mem[b + 3], {31'd0, is_compressed_o});
    check_value("illegal_o", stim_mem[b + 4], {31'd0, illegal_o});
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_rdata_i = 32'h0;
    stall_i       = 1'b0;
    seed          = 32'h7f44;
    pend_v        = 1'b0;
    pend_addr     = 32'h0;
    req_seen      = 1'b0;
    err_count     = 0;
    check_count   = 0;
    timeout_count = 0;
    load_stim();
    // quiet during reset and in the cycle it is released
    repeat (2) begin
      @(posedge clk_i);
      #1;
      check_value("valid_o", 32'h0, {31'd0, valid_o});
      check_value("fetch_req_o", 32'h0, {31'd0, fetch_req_o});
    end
    rst_i = 1'b0;
    ok    = 1'b1;
    for (int unsigned r = 0; r < rec_count && ok; r++) begin
      wait_valid(ok);
      if (ok) begin
        check_record(r);
      end
    end
    $display("checks %0d, mismatches %0d, timeouts %0d, records %0d",
             check_count, err_count, timeout_count, rec_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== sim/rvc_fetch_stim.txt ====
// memory image: one 32-bit word per entry, from the boot address up, ends at deadbeef
// records: pc, expanded instr, original bits, is_compressed, illegal; ends at deadbeef
002081b3 52b70800 41441234 10f5c504 bff52021 6305429d 03136105 800d7ff0
997d8491 8c258c05 8c658c45 fcfdc401 45b20396 80828636 90029636 c43a9282
40120004 900d8002 00932004 00010010 00a00513
deadbeef
00000080 002081b3 002081b3 00000000 00000000
00000084 01010413 00000800 00000001 00000000
00000086 123452b7 123452b7 00000000 00000000
0000008a 00452483 00004144 00000001 00000000
0000008c 00952423 0000c504 00000001 00000000
0000008e ffd08093 000010f5 00000001 00000000
00000090 008000ef 00002021 00000001 00000000
00000092 ffdff06f 0000bff5 00000001 00000000
00000094 00700293 0000429d 00000001 00000000
00000096 00001337 00006305 00000001 00000000
00000098 02010113 00006105 00000001 00000000
0000009a 7ff00313 7ff00313 00000000 00000000
0000009e 00345413 0000800d 00000001 00000000
000000a0 4044d493 00008491 00000001 00000000
000000a2 fff57513 0000997d 00000001 00000000
000000a4 40940433 00008c05 00000001 00000000
000000a6 00944433 00008c25 00000001 00000000
000000a8 00946433 00008c45 00000001 00000000
000000aa 00947433 00008c65 00000001 00000000
000000ac 00040463 0000c401 00000001 00000000
000000ae fe049fe3 0000fcfd 00000001 00000000
000000b0 00539393 00000396 00000001 00000000
000000b2 00c12583 000045b2 00000001 00000000
000000b4 00d00633 00008636 00000001 00000000
000000b6 00008067 00008082 00000001 00000000
000000b8 00d60633 00009636 00000001 00000000
000000ba 00100073 00009002 00000001 00000000
000000bc 000280e7 00009282 00000001 00000000
000000be 00e12423 0000c43a 00000001 00000000
000000c0 00000000 00000004 00000001 00000001
000000c2 00000000 00004012 00000001 00000001
000000c4 00000000 00008002 00000001 00000001
000000c6 00000000 0000900d 00000001 00000001
000000c8 00000000 00002004 00000001 00000001
000000ca 00100093 00100093 00000000 00000000
000000ce 00000013 00000001 00000001 00000000
000000d0 00a00513 00a00513 00000000 00000000
deadbeef

// ==== rvc_fetch_top.f ====
common/rvc_pkg.sv
hw/fetch/fetch_prefetch.sv
hw/fetch/fetch_aligner.sv
hw/decode/compressed_decoder.sv
hw/decode/if_output_reg.sv
hw/rvc_fetch_top.sv
sim/rvc_fetch_chk.sv
sim/tb_rvc_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator, from the project root
verilator --binary --timing --assert --top-module tb_rvc_fetch \
  -f rvc_fetch_top.f -o sim_rvc_fetch > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_rvc_fetch > sim.log 2>&1 || echo "simulator returned an error status"
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL, no result line"; exit 1; }
echo "PASS"
